/* design/debug_pkg.sv */
package debug_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and sizes.
    //////////////////////////////////////////////////////////////////////
    localparam int BYTE_W     = 8;          // UART data width.
    localparam int WORD_W     = 32;         // Instruction and report word.
    localparam int ADDR_W     = 6;          // Program address width.
    localparam int PROG_DEPTH = 64;         // Words of program memory.

    // UART timing, small enough to simulate.
    localparam int BAUD_DIV   = 4;          // Clocks per oversampling tick.
    localparam int OVERSAMPLE = 16;         // Ticks per bit.
    localparam int STOP_BITS  = 2;
    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
    localparam int TICK_W     = $clog2(OVERSAMPLE);
    localparam int BIT_CNT_W  = $clog2(BYTE_W);

    // Opcode field of an instruction.
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam logic [OPCODE_MSB-OPCODE_LSB:0] HALT_OPCODE = '0;

    // Host command bytes.
    typedef enum logic [7:0] {
        CMD_LOAD = 8'h4C,                   // 'L'.
        CMD_RUN  = 8'h52,                   // 'R'.
        CMD_STEP = 8'h53                    // 'S'.
    } cmd_e;

    // Report word select.
    typedef enum logic [1:0] {
        SEL_PC     = 2'd0,
        SEL_CYCLES = 2'd1,
        SEL_INSTR  = 2'd2
    } db_sel_e;

    // Loader write request.
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
    } mem_wr_t;

endpackage

/* design/baud_rate_generator.sv */
`timescale 1ns/1ps

module baud_rate_generator (
    input  logic i_clock,
    input  logic i_rst,
    output logic o_tick
);

    logic [debug_pkg::BAUD_CNT_W-1:0] cnt;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else begin
            o_tick <= (cnt == debug_pkg::BAUD_CNT_W'(debug_pkg::BAUD_DIV - 1));
            cnt    <= cnt + 1'b1;               // Wraps at BAUD_DIV.
        end
    end

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_tick,
    input  logic                         i_rx,
    output logic                         o_rx_done,
    output logic [debug_pkg::BYTE_W-1:0] o_data
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e                       state;
    logic [debug_pkg::TICK_W-1:0]    s_cnt;     // Ticks within a bit.
    logic [debug_pkg::BIT_CNT_W-1:0] n_cnt;     // Data bits received.

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state     <= RX_IDLE;
            s_cnt     <= '0;
            n_cnt     <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            case (state)
                RX_IDLE: if (!i_rx) begin          // Falling edge, maybe a start.
                    s_cnt <= '0;
                    state <= RX_START;
                end
                RX_START: if (i_tick) begin
                    if (s_cnt == debug_pkg::TICK_W'(debug_pkg::OVERSAMPLE/2 - 1)) begin
                        s_cnt <= '0;
                        n_cnt <= '0;
                        state <= i_rx ? RX_IDLE : RX_DATA;  // Glitch goes back to idle.
                    end else begin
                        s_cnt <= s_cnt + 1'b1;
                    end
                end
                RX_DATA: if (i_tick) begin
                    s_cnt <= s_cnt + 1'b1;
                    if (s_cnt == debug_pkg::TICK_W'(debug_pkg::OVERSAMPLE - 1)) begin
                        o_data <= {i_rx, o_data[debug_pkg::BYTE_W-1:1]};  // LSB first.
                        n_cnt  <= n_cnt + 1'b1;
                        if (n_cnt == debug_pkg::BIT_CNT_W'(debug_pkg::BYTE_W - 1))
                            state <= RX_STOP;
                    end
                end
                RX_STOP: if (i_tick) begin
                    s_cnt <= s_cnt + 1'b1;
                    // Middle of the first stop bit.
                    if (s_cnt == debug_pkg::TICK_W'(debug_pkg::OVERSAMPLE - 1)) begin
                        o_rx_done <= 1'b1;
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_tick,
    input  logic                         i_tx_start,
    input  logic [debug_pkg::BYTE_W-1:0] i_data,
    output logic                         o_tx,
    output logic                         o_tx_done
);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e                       state;
    logic [debug_pkg::TICK_W-1:0]    s_cnt;
    logic [debug_pkg::BIT_CNT_W-1:0] n_cnt;     // Data bits, then stop bits.
    logic [debug_pkg::BYTE_W-1:0]    shreg;
    logic                            bit_end;

    assign bit_end = i_tick && (s_cnt == debug_pkg::TICK_W'(debug_pkg::OVERSAMPLE - 1));
    assign o_tx    = (state == TX_DATA) ? shreg[0] : (state != TX_START);  // Idles high.

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state     <= TX_IDLE;
            s_cnt     <= '0;
            n_cnt     <= '0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (i_tick)
                s_cnt <= s_cnt + 1'b1;
            case (state)
                TX_IDLE: if (i_tx_start) begin
                    shreg <= i_data;
                    s_cnt <= '0;
                    state <= TX_START;
                end
                TX_START: if (bit_end) begin
                    n_cnt <= '0;
                    state <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    shreg <= shreg >> 1;
                    n_cnt <= n_cnt + 1'b1;
                    if (n_cnt == debug_pkg::BIT_CNT_W'(debug_pkg::BYTE_W - 1))
                        state <= TX_STOP;   // Counter wraps to zero here.
                end
                TX_STOP: if (bit_end) begin
                    n_cnt <= n_cnt + 1'b1;
                    if (n_cnt == debug_pkg::BIT_CNT_W'(debug_pkg::STOP_BITS - 1)) begin
                        o_tx_done <= 1'b1;
                        state     <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // The debug unit waits for done before the next byte.
    a_no_start_busy: assert property (@(posedge i_clock) disable iff (i_rst)
        (state != TX_IDLE) |-> !i_tx_start);

endmodule

/* design/debug_unit.sv */
`timescale 1ns/1ps

module debug_unit (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_rx_done,
    input  logic [debug_pkg::BYTE_W-1:0] i_rx_data,
    input  logic                         i_tx_done,
    input  logic [debug_pkg::WORD_W-1:0] i_instruction,
    input  logic [debug_pkg::WORD_W-1:0] i_trace_word,
    input  logic                         i_clear_ack,
    output logic                         o_tx_start,
    output logic [debug_pkg::BYTE_W-1:0] o_tx_data,
    output logic                         o_soft_reset,
    output debug_pkg::mem_wr_t           o_mem_wr,
    output logic                         o_enable_pc,
    output debug_pkg::db_sel_e           o_db_sel,
    output logic [1:0]                   o_leds
);

    typedef enum logic [2:0] {IDLE, CLEAR, ACK, LOAD, EXEC, WAIT, REPORT} state_e;

    state_e                       state;
    logic                         step_mode;    // Step, else run.
    logic                         wait_cnt;
    logic                         tx_busy;      // Report byte in flight.
    logic [1:0]                   byte_cnt;     // Bytes of the load word.
    logic [3:0]                   rep_idx;      // Report byte, 0 to 11.
    logic                         is_halt;
    logic [debug_pkg::WORD_W-1:0] next_word;

    assign is_halt     = (i_instruction[debug_pkg::OPCODE_MSB:debug_pkg::OPCODE_LSB]
                          == debug_pkg::HALT_OPCODE);
    assign next_word   = {i_rx_data, o_mem_wr.data[debug_pkg::WORD_W-1:debug_pkg::BYTE_W]};
    assign o_enable_pc = (state == EXEC) && !is_halt;  // One advance per check.
    assign o_db_sel    = debug_pkg::db_sel_e'(rep_idx[3:2]);  // Four bytes per word.

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state        <= IDLE;
            step_mode    <= 1'b0;
            wait_cnt     <= 1'b0;
            tx_busy      <= 1'b0;
            byte_cnt     <= '0;
            rep_idx      <= '0;
            o_tx_start   <= 1'b0;
            o_soft_reset <= 1'b0;
            o_mem_wr.en  <= 1'b0;
            o_leds       <= '0;
        end else begin
            o_tx_start   <= 1'b0;               // Strobes last one cycle.
            o_soft_reset <= 1'b0;
            o_mem_wr.en  <= 1'b0;
            if (o_mem_wr.en)
                o_mem_wr.addr <= o_mem_wr.addr + 1'b1;
            case (state)
                //////////////////////////////////////////////////////////////
                // Command decode and load.
                //////////////////////////////////////////////////////////////
                IDLE: if (i_rx_done) begin
                    case (debug_pkg::cmd_e'(i_rx_data))
                        debug_pkg::CMD_LOAD: begin
                            o_soft_reset <= 1'b1;   // Clear memory and counters.
                            o_leds[1]    <= 1'b0;
                            state        <= CLEAR;
                        end
                        debug_pkg::CMD_RUN: begin
                            step_mode <= 1'b0;
                            state     <= EXEC;
                        end
                        debug_pkg::CMD_STEP: begin
                            step_mode <= 1'b1;
                            state     <= EXEC;
                        end
                        default: ;                  // Unknown byte ignored.
                    endcase
                end
                CLEAR: if (i_clear_ack) begin
                    o_tx_start <= 1'b1;             // Echo the command.
                    o_tx_data  <= debug_pkg::CMD_LOAD;
                    state      <= ACK;
                end
                ACK: if (i_tx_done) begin
                    byte_cnt      <= '0;
                    o_mem_wr.addr <= '0;
                    state         <= LOAD;
                end
                LOAD: if (i_rx_done) begin
                    o_mem_wr.data <= next_word;     // LSB first.
                    byte_cnt      <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd3) begin
                        o_mem_wr.en <= 1'b1;        // Write next cycle.
                        if (next_word[debug_pkg::OPCODE_MSB:debug_pkg::OPCODE_LSB]
                                == debug_pkg::HALT_OPCODE) begin
                            o_leds[1] <= 1'b1;      // Program complete.
                            state     <= IDLE;
                        end
                    end
                end
                //////////////////////////////////////////////////////////////
                // Execution and report.
                //////////////////////////////////////////////////////////////
                EXEC: begin
                    if (is_halt && !step_mode) begin
                        rep_idx <= '0;
                        tx_busy <= 1'b0;
                        state   <= REPORT;
                    end else begin
                        wait_cnt <= step_mode;      // Step waits two cycles.
                        state    <= WAIT;
                    end
                end
                WAIT: begin
                    wait_cnt <= 1'b0;
                    if (!wait_cnt) begin
                        rep_idx <= '0;
                        tx_busy <= 1'b0;
                        state   <= step_mode ? REPORT : EXEC;
                    end
                end
                REPORT: begin
                    if (!tx_busy) begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= i_trace_word[rep_idx[1:0]*debug_pkg::BYTE_W +:
                                                   debug_pkg::BYTE_W];
                        tx_busy    <= 1'b1;
                    end else if (i_tx_done) begin
                        tx_busy <= 1'b0;
                        rep_idx <= rep_idx + 1'b1;
                        if (rep_idx == 4'd11) begin
                            o_leds[0] <= is_halt;   // Halt reached.
                            state     <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // A run report shows the halt that ended the run, so fetch stays put.
    a_run_report_on_halt: assert property (@(posedge i_clock) disable iff (i_rst)
        (state == REPORT) && !step_mode |-> is_halt);

endmodule

/* design/program_memory.sv */
`timescale 1ns/1ps

module program_memory (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_soft_reset,
    input  debug_pkg::mem_wr_t           i_mem_wr,
    input  logic [debug_pkg::ADDR_W-1:0] i_rd_addr,
    output logic [debug_pkg::WORD_W-1:0] o_instruction,
    output logic                         o_clear_ack
);

    logic [debug_pkg::WORD_W-1:0] mem [debug_pkg::PROG_DEPTH];
    logic                         clearing;
    logic [debug_pkg::ADDR_W-1:0] clr_addr;

    // Clear engine, one word per cycle.
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            clearing    <= 1'b0;
            clr_addr    <= '0;
            o_clear_ack <= 1'b0;
        end else begin
            o_clear_ack <= 1'b0;
            if (i_soft_reset) begin
                clearing <= 1'b1;
                clr_addr <= '0;
            end else if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == debug_pkg::ADDR_W'(debug_pkg::PROG_DEPTH - 1)) begin
                    clearing    <= 1'b0;
                    o_clear_ack <= 1'b1;    // Last word zeroed.
                end
            end
        end
    end

    // Fixed priority: clear, load write, fetch read.
    always_ff @(posedge i_clock) begin
        if (clearing)
            mem[clr_addr] <= '0;
        else if (i_mem_wr.en)
            mem[i_mem_wr.addr] <= i_mem_wr.data;
        else
            o_instruction <= mem[i_rd_addr];  // Lost read holds old word.
    end

    a_no_write_clearing: assert property (@(posedge i_clock) disable iff (i_rst)
        clearing |-> !i_mem_wr.en);

endmodule

/* design/instruction_fetch.sv */
`timescale 1ns/1ps

module instruction_fetch (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_soft_reset,
    input  logic                         i_enable_pc,
    output logic [debug_pkg::ADDR_W-1:0] o_pc
);

    always_ff @(posedge i_clock) begin
        if (i_rst || i_soft_reset) begin
            o_pc <= '0;
        end else if (i_enable_pc) begin
            if (o_pc == debug_pkg::ADDR_W'(debug_pkg::PROG_DEPTH - 1))
                o_pc <= '0;                     // Wrap at the end of memory.
            else
                o_pc <= o_pc + 1'b1;            // No branches, increment only.
        end
    end

endmodule

/* design/trace_database.sv */
`timescale 1ns/1ps

module trace_database (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_soft_reset,
    input  logic                         i_enable_pc,
    input  logic [debug_pkg::ADDR_W-1:0] i_pc,
    input  logic [debug_pkg::WORD_W-1:0] i_instruction,
    input  debug_pkg::db_sel_e           i_db_sel,
    output logic [debug_pkg::WORD_W-1:0] o_trace_word
);

    logic [debug_pkg::WORD_W-1:0] cycles;   // Executed instructions.

    always_ff @(posedge i_clock) begin
        if (i_rst || i_soft_reset)
            cycles <= '0;
        else if (i_enable_pc)
            cycles <= cycles + 1'b1;
    end

    // Report word mux.
    always_comb begin
        case (i_db_sel)
            debug_pkg::SEL_PC:     o_trace_word = debug_pkg::WORD_W'(i_pc);
            debug_pkg::SEL_CYCLES: o_trace_word = cycles;
            default:               o_trace_word = i_instruction;
        endcase
    end

endmodule

/* design/mips_debug_top.sv */
`timescale 1ns/1ps

module mips_debug_top (
    input  logic       i_clock,
    input  logic       i_rst,
    input  logic       i_uart_rx,
    output logic       o_uart_tx,
    output logic [1:0] o_leds
);

    //////////////////////////////////////////////////////////////////////
    // Interconnect.
    //////////////////////////////////////////////////////////////////////
    logic                         tick;
    logic                         rx_done;
    logic [debug_pkg::BYTE_W-1:0] rx_data;
    logic                         tx_start;
    logic [debug_pkg::BYTE_W-1:0] tx_data;
    logic                         tx_done;
    logic                         soft_reset;   // Clears memory, PC and count.
    logic                         clear_ack;
    debug_pkg::mem_wr_t           mem_wr;
    logic [debug_pkg::ADDR_W-1:0] pc;
    logic [debug_pkg::WORD_W-1:0] instruction;
    logic                         enable_pc;
    debug_pkg::db_sel_e           db_sel;
    logic [debug_pkg::WORD_W-1:0] trace_word;

    baud_rate_generator u_baud_rate_generator (
        .i_clock (i_clock), .i_rst (i_rst), .o_tick (tick)
    );

    uart_rx u_uart_rx (
        .i_clock (i_clock), .i_rst (i_rst), .i_tick (tick), .i_rx (i_uart_rx),
        .o_rx_done (rx_done), .o_data (rx_data)
    );

    uart_tx u_uart_tx (
        .i_clock (i_clock), .i_rst (i_rst), .i_tick (tick), .i_tx_start (tx_start),
        .i_data (tx_data), .o_tx (o_uart_tx), .o_tx_done (tx_done)
    );

    debug_unit u_debug_unit (
        .i_clock (i_clock), .i_rst (i_rst),
        .i_rx_done (rx_done), .i_rx_data (rx_data), .i_tx_done (tx_done),
        .i_instruction (instruction), .i_trace_word (trace_word),
        .i_clear_ack (clear_ack),
        .o_tx_start (tx_start), .o_tx_data (tx_data), .o_soft_reset (soft_reset),
        .o_mem_wr (mem_wr), .o_enable_pc (enable_pc), .o_db_sel (db_sel),
        .o_leds (o_leds)
    );

    program_memory u_program_memory (
        .i_clock (i_clock), .i_rst (i_rst), .i_soft_reset (soft_reset),
        .i_mem_wr (mem_wr), .i_rd_addr (pc),
        .o_instruction (instruction), .o_clear_ack (clear_ack)
    );

    instruction_fetch u_instruction_fetch (
        .i_clock (i_clock), .i_rst (i_rst), .i_soft_reset (soft_reset),
        .i_enable_pc (enable_pc), .o_pc (pc)
    );

    trace_database u_trace_database (
        .i_clock (i_clock), .i_rst (i_rst), .i_soft_reset (soft_reset),
        .i_enable_pc (enable_pc), .i_pc (pc), .i_instruction (instruction),
        .i_db_sel (db_sel), .o_trace_word (trace_word)
    );

endmodule

/* tests/tb_mips_debug.sv */
`timescale 1ns/1ps

module tb_mips_debug;

    //////////////////////////////////////////////////////////////////////
    // Timing and run length.
    //////////////////////////////////////////////////////////////////////
    localparam int HALF_PERIOD = 10;                // 20 ns clock.
    localparam int DRV_DLY     = 2;                 // Drive and sample after the edge.
    localparam int BIT_CLKS    = debug_pkg::OVERSAMPLE * debug_pkg::BAUD_DIV;
    localparam int FRAME_CLKS  = (1 + debug_pkg::BYTE_W + debug_pkg::STOP_BITS) * BIT_CLKS;
    localparam int MAX_LEN     = 20;                // Longest random program.
    localparam int NUM_STEPS   = 4;
    localparam int LOAD_BYTES  = 2 + 4 * MAX_LEN;   // Command, ack, words.
    localparam int REP_BYTES   = 13;                // Command and 12-byte report.
    localparam int TOTAL_BYTES = 5 * LOAD_BYTES + (NUM_STEPS + 8) * REP_BYTES;
    localparam int TIMEOUT     = 2 * TOTAL_BYTES * FRAME_CLKS;

    logic        clk = 1'b0;
    logic        rst;
    logic        uart_rx;
    logic        uart_tx;
    logic [1:0]  leds;
    logic        rst_done = 1'b0;
    logic [31:0] lcg_state = 32'd11;                // Fixed seed.
    logic [31:0] model_mem [debug_pkg::PROG_DEPTH]; // Reference copy of memory.
    int          model_pc;
    int          model_cycles;
    logic [7:0]  rx_q [$];                          // Bytes heard from the DUT.
    logic [7:0]  mon_byte;
    int          cycle_cnt = 0;
    int          errors = 0;
    int          test_errs = 0;
    int          tests_failed = 0;
    int          test_num = 0;

    mips_debug_top dut0 (
        .i_clock (clk), .i_rst (rst), .i_uart_rx (uart_rx),
        .o_uart_tx (uart_tx), .o_leds (leds)
    );

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;  // 32-bit LCG.
        return lcg_state;
    endfunction

    function automatic logic word_is_halt(logic [31:0] w);
        return w[debug_pkg::OPCODE_MSB:debug_pkg::OPCODE_LSB] == debug_pkg::HALT_OPCODE;
    endfunction

    function automatic void model_advance();
        model_pc     = (model_pc + 1) % debug_pkg::PROG_DEPTH;
        model_cycles = model_cycles + 1;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic wait_cycles(int n);
        repeat (n) next_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host UART.
    //////////////////////////////////////////////////////////////////////
    task automatic send_byte(logic [7:0] b);
        int i;
        wait_cycles(debug_pkg::STOP_BITS * BIT_CLKS);   // Idle gap.
        uart_rx = 1'b0;                                 // Start bit.
        wait_cycles(BIT_CLKS);
        for (i = 0; i < 8; i++) begin
            uart_rx = b[i];                             // LSB first.
            wait_cycles(BIT_CLKS);
        end
        uart_rx = 1'b1;
    endtask

    // Receive side, bytes queued as they arrive.
    initial begin : uart_monitor
        int i;
        wait (rst_done);
        forever begin
            next_cycle();
            if (uart_tx === 1'b0) begin
                wait_cycles(BIT_CLKS / 2 - 1);          // Middle of start bit.
                if (uart_tx === 1'b0) begin
                    for (i = 0; i < 8; i++) begin
                        wait_cycles(BIT_CLKS);
                        mon_byte[i] = uart_tx;
                    end
                    wait_cycles(BIT_CLKS);
                    if (uart_tx !== 1'b1) begin
                        $display("ERROR %0t o_uart_tx (stop bit): expected 1 got %0b",
                                 $time, uart_tx);
                        test_errs++;
                    end
                    rx_q.push_back(mon_byte);
                end
            end
        end
    end

    task automatic expect_byte(logic [7:0] exp, string what);
        int         waited;
        logic [7:0] got;
        waited = 0;
        while (rx_q.size() == 0 && waited < 3 * FRAME_CLKS) begin
            next_cycle();
            waited++;
        end
        if (rx_q.size() == 0) begin
            $display("No byte came back from the DUT for the %s at %0t.", what, $time);
            test_errs++;
        end else begin
            got = rx_q.pop_front();
            if (got !== exp) begin
                $display("ERROR %0t o_uart_tx (%s): expected 0x%02h got 0x%02h",
                         $time, what, exp, got);
                test_errs++;
            end
        end
    endtask

    task automatic check_led(int idx, logic exp);
        if (leds[idx] !== exp) begin
            $display("ERROR %0t o_leds[%0d]: expected %0b got %0b", $time, idx, exp, leds[idx]);
            test_errs++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Commands against the reference model.
    //////////////////////////////////////////////////////////////////////
    task automatic load_program(int n);
        logic [31:0] w;
        int          i;
        int          j;
        for (i = 0; i < debug_pkg::PROG_DEPTH; i++)
            model_mem[i] = '0;                          // Clear before load.
        send_byte(debug_pkg::CMD_LOAD);
        expect_byte(debug_pkg::CMD_LOAD, "load acknowledgement");
        for (i = 0; i < n; i++) begin
            w = next_rand();
            if (i == n - 1)
                w[31:26] = '0;                          // Halt closes it.
            else
                w[31:26] = 6'(1 + (next_rand() >> 16) % 63);
            model_mem[i] = w;
            for (j = 0; j < 4; j++)
                send_byte(w[8*j +: 8]);
        end
        model_pc     = 0;
        model_cycles = 0;
        wait_cycles(BIT_CLKS);
        check_led(1, 1'b1);
    endtask

    task automatic exec_cmd(logic [7:0] cmd);
        logic [31:0] words [3];
        int          k;
        if (cmd == debug_pkg::CMD_RUN) begin
            while (!word_is_halt(model_mem[model_pc]))
                model_advance();
        end else if (!word_is_halt(model_mem[model_pc])) begin
            model_advance();                            // One step.
        end
        words[0] = 32'(model_pc);
        words[1] = 32'(model_cycles);
        words[2] = model_mem[model_pc];
        send_byte(cmd);
        for (k = 0; k < 12; k++)
            expect_byte(words[k/4][8*(k%4) +: 8], $sformatf("report byte %0d", k));
        wait_cycles(2 * BIT_CLKS);                      // Past the last stop bit.
        check_led(0, word_is_halt(model_mem[model_pc]));
    endtask

    task automatic start_test();
        test_num++;
        test_errs = 0;
    endtask

    task automatic finish_test(string name);
        errors += test_errs;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_num, name, test_errs);
        end
    endtask

    initial begin
        int long_n;
        int n;
        rst     = 1'b1;
        uart_rx = 1'b1;                                 // Line idles high.
        wait_cycles(4);
        rst      = 1'b0;
        rst_done = 1'b1;
        wait_cycles(10);

        start_test();
        load_program(1 + (next_rand() >> 16) % MAX_LEN);
        exec_cmd(debug_pkg::CMD_RUN);
        finish_test("load then run");

        start_test();
        load_program(2 + (next_rand() >> 16) % (MAX_LEN - 1));
        repeat (NUM_STEPS) exec_cmd(debug_pkg::CMD_STEP);
        finish_test("load then steps");

        start_test();
        exec_cmd(debug_pkg::CMD_RUN);
        exec_cmd(debug_pkg::CMD_STEP);                  // Stays at halt.
        exec_cmd(debug_pkg::CMD_STEP);
        finish_test("step at halt");

        start_test();
        long_n = 12 + (next_rand() >> 16) % 9;
        load_program(long_n);
        exec_cmd(debug_pkg::CMD_RUN);
        load_program(1 + (next_rand() >> 16) % (long_n - 1));   // Shorter one.
        exec_cmd(debug_pkg::CMD_RUN);
        finish_test("reload shorter program");

        start_test();
        n = 3 + (next_rand() >> 16) % 10;
        load_program(n);
        exec_cmd(debug_pkg::CMD_STEP);                  // Not at halt yet.
        exec_cmd(debug_pkg::CMD_RUN);
        finish_test("leds");

        if (rx_q.size() != 0) begin
            $display("The DUT sent %0d bytes that nothing asked for.", rx_q.size());
            errors++;
        end
        $display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* list.f */
design/debug_pkg.sv
design/baud_rate_generator.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_unit.sv
design/program_memory.sv
design/instruction_fetch.sv
design/trace_database.sv
design/mips_debug_top.sv
tests/tb_mips_debug.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_debug -f list.f
out=$(./obj_dir/Vtb_mips_debug)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi
exit 1
